//--- hw/cart_hdr_pkg.sv
/*
 * cartridge header layout: word and address types, region codes,
 * header field codes, header byte addresses and region characters
 */

package cart_hdr_pkg;

	typedef logic [24:0] rom_addr_t;   // byte address of a download word
	typedef logic [15:0] rom_word_t;
	typedef logic [1:0]  region_t;

	// field codes from the decode stage
	typedef enum logic [2:0] {
		none,
		region_lo,      // word at 0x1f0, both bytes carry region info
		region_hi_b2,   // word at 0x1f2, low byte only
		id_first,
		id_mid,         // three words, arrive in address order
		id_last,
		id_check,
		hdr_end
	} hdr_field_e;

	////////////////////////////////////////
	// header addresses
	localparam rom_addr_t addr_region   = 25'h1F0;
	localparam rom_addr_t addr_region2  = 25'h1F2;
	localparam rom_addr_t addr_id0      = 25'h182;
	localparam rom_addr_t addr_id1      = 25'h184;
	localparam rom_addr_t addr_id2      = 25'h186;
	localparam rom_addr_t addr_id3      = 25'h188;
	localparam rom_addr_t addr_id4      = 25'h18A;
	localparam rom_addr_t addr_id_check = 25'h18C;
	localparam rom_addr_t addr_hdr_end  = 25'h200;

	////////////////////////////////////////
	// region characters and codes
	localparam logic [7:0] char_j = "J";
	localparam logic [7:0] char_u = "U";
	localparam logic [7:0] char_e = "E";

	localparam region_t region_jp = 2'd0;
	localparam region_t region_us = 2'd1;
	localparam region_t region_eu = 2'd2;
	localparam region_t region_default = region_us;

endpackage

//--- hw/cart_quirk_pkg.sv
/*
 * compatibility quirks: flag and product-code types, flag indices,
 * quirk table and light-gun timing constants
 */

package cart_quirk_pkg;

	typedef logic [63:0] product_code_t;   // eight ascii chars, first char in msb
	typedef logic [7:0]  quirk_flags_t;
	typedef logic [7:0]  gun_delay_t;

	// bit positions in quirk_flags_t
	localparam int quirk_sram   = 0;
	localparam int quirk_sram00 = 1;
	localparam int quirk_eeprom = 2;
	localparam int quirk_noram  = 3;
	localparam int quirk_fifo   = 4;
	localparam int quirk_pier   = 5;
	localparam int quirk_svp    = 6;
	localparam int quirk_fmbusy = 7;

	////////////////////////////////////////
	// product codes
	localparam product_code_t code_sram          = "T-081276";
	localparam product_code_t code_sram00        = " GM 0000";
	localparam product_code_t code_eeprom_a      = "MK-1215 ";
	localparam product_code_t code_eeprom_b      = "G-4060  ";
	localparam product_code_t code_noram         = "T-113016";  // fake ram check
	localparam product_code_t code_fifo          = "T-89016 ";
	localparam product_code_t code_pier          = "T-574023";
	localparam product_code_t code_svp           = "MK-1229 ";
	localparam product_code_t code_fmbusy        = "T-35036 ";
	localparam product_code_t code_gun_lethal    = "T-95096-";
	localparam product_code_t code_gun_bodycount = "MK-1533 ";

	// flag table, one entry per code
	localparam int quirk_count = 9;

	localparam product_code_t quirk_code [quirk_count] = '{
		code_sram, code_sram00, code_eeprom_a, code_eeprom_b, code_noram,
		code_fifo, code_pier, code_svp, code_fmbusy
	};

	localparam quirk_flags_t quirk_mask [quirk_count] = '{
		quirk_flags_t'(1) << quirk_sram,
		quirk_flags_t'(1) << quirk_sram00,
		quirk_flags_t'(1) << quirk_eeprom,
		quirk_flags_t'(1) << quirk_eeprom,
		quirk_flags_t'(1) << quirk_noram,
		quirk_flags_t'(1) << quirk_fifo,
		quirk_flags_t'(1) << quirk_pier,
		quirk_flags_t'(1) << quirk_svp,
		quirk_flags_t'(1) << quirk_fmbusy
	};

	////////////////////////////////////////
	// light-gun sensor timing
	localparam gun_delay_t gun_delay_default   = 8'd44;   // with gun type 0
	localparam gun_delay_t gun_delay_lethal    = 8'd52;   // gun type 1
	localparam gun_delay_t gun_delay_bodycount = 8'd100;  // gun type 0

endpackage

//--- hw/cart_word_port.sv
/*
 * four-phase req/ack receiver for download words, word strobe
 * and download start/end pulses
 */

module cart_word_port (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   dl_active,
	input  logic                   word_req,
	input  cart_hdr_pkg::rom_addr_t word_addr,
	input  cart_hdr_pkg::rom_word_t word_data,
	output logic                   word_ack,
	output logic                   word_stb,
	output cart_hdr_pkg::rom_addr_t stb_addr,
	output cart_hdr_pkg::rom_word_t stb_data,
	output logic                   dl_start,
	output logic                   dl_end
);

	typedef enum logic {
		idle,
		acked
	} port_state_e;

	port_state_e state;
	logic        dl_q;   // dl_active one cycle late

	assign word_ack = (state == acked);

	// handshake fsm
	always_ff @(posedge clk_sys) begin
		word_stb <= 1'b0;
		if (reset) begin
			state <= idle;
		end else begin
			case (state)
				idle: if (word_req) begin
					state    <= acked;
					word_stb <= dl_active;   // acked but dropped outside a download
				end
				acked: if (!word_req) state <= idle;   // wait for req low
				default: state <= idle;
			endcase
		end
	end

	// captured word, held until the next capture
	always_ff @(posedge clk_sys) begin
		if (state == idle && word_req) begin
			stb_addr <= word_addr;
			stb_data <= word_data;
		end
	end

	// download edges
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_q     <= 1'b0;
			dl_start <= 1'b0;
			dl_end   <= 1'b0;
		end else begin
			dl_q     <= dl_active;
			dl_start <= dl_active & ~dl_q;
			dl_end   <= ~dl_active & dl_q;
		end
	end

endmodule

//--- hw/hdr_field_decode.sv
/*
 * decode stage: maps a strobed word address onto a header field code
 */

module hdr_field_decode (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      word_stb,
	input  cart_hdr_pkg::rom_addr_t   stb_addr,
	input  cart_hdr_pkg::rom_word_t   stb_data,
	output logic                      field_stb,
	output cart_hdr_pkg::hdr_field_e  field,
	output cart_hdr_pkg::rom_word_t   field_data
);

	import cart_hdr_pkg::*;

	hdr_field_e field_nx;

	always_comb begin
		case (stb_addr)
			addr_region:   field_nx = region_lo;
			addr_region2:  field_nx = region_hi_b2;
			addr_id0:      field_nx = id_first;
			addr_id1,
			addr_id2,
			addr_id3:      field_nx = id_mid;
			addr_id4:      field_nx = id_last;
			addr_id_check: field_nx = id_check;
			addr_hdr_end:  field_nx = hdr_end;
			default:       field_nx = none;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			field_stb <= 1'b0;
			field     <= none;
		end else begin
			field_stb <= word_stb && (field_nx != none);
			field     <= word_stb ? field_nx : none;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (word_stb) field_data <= stb_data;
	end

endmodule

//--- hw/region_detect.sv
/*
 * execute stage: region flag collection from the header's region
 * characters, region pick at header end
 */

module region_detect (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      dl_start,
	input  logic                      dl_end,
	input  logic                      field_stb,
	input  cart_hdr_pkg::hdr_field_e  field,
	input  cart_hdr_pkg::rom_word_t   field_data,
	output cart_hdr_pkg::region_t     region,
	output logic                      hdr_ready_rise
);

	import cart_hdr_pkg::*;

	logic [2:0] flags;      // {e, u, j}
	logic [2:0] flags_nx;
	logic [7:0] lo_byte;
	logic [7:0] hi_byte;
	logic [3:0] hex_adj;    // 'A'..'F' folded onto the digit encoding
	logic       hdr_ready;
	logic       hdr_hit;

	function automatic logic [2:0] letter_flags(input logic [7:0] ch);
		return {ch == char_e, ch == char_u, ch == char_j};
	endfunction

	assign lo_byte = field_data[7:0];
	assign hi_byte = field_data[15:8];
	assign hex_adj = lo_byte[3:0] - 4'd7;
	assign hdr_hit = field_stb && (field == hdr_end);

	always_comb begin
		flags_nx = flags;
		if (field_stb && field == region_lo) begin
			if (letter_flags(lo_byte) != 3'b000)
				flags_nx = flags_nx | letter_flags(lo_byte);
			else if (lo_byte >= "0" && lo_byte <= "9")
				flags_nx = {lo_byte[3], lo_byte[2], lo_byte[0]};   // digit is a bit mask
			else if (lo_byte >= "A" && lo_byte <= "F")
				flags_nx = {hex_adj[3], hex_adj[2], hex_adj[0]};
			flags_nx = flags_nx | letter_flags(hi_byte);
		end else if (field_stb && field == region_hi_b2) begin
			flags_nx = flags_nx | letter_flags(lo_byte);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			flags          <= 3'b000;
			hdr_ready      <= 1'b0;
			hdr_ready_rise <= 1'b0;
			region         <= region_default;
		end else begin
			flags          <= dl_start ? 3'b000 : flags_nx;
			hdr_ready_rise <= hdr_hit && !hdr_ready;   // first 0x200 only
			if (dl_end) hdr_ready <= 1'b0;
			else if (hdr_hit) hdr_ready <= 1'b1;
			if (hdr_hit && !hdr_ready) begin
				if (flags[1]) region <= region_us;        // u wins
				else if (flags[2]) region <= region_eu;
				else if (flags[0]) region <= region_jp;
				else region <= region_default;
			end
		end
	end

endmodule

//--- hw/quirk_match.sv
/*
 * execute stage: product-code assembly from the header id words,
 * quirk table match and light-gun timing
 */

module quirk_match (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  logic                          dl_start,
	input  logic                          field_stb,
	input  cart_hdr_pkg::hdr_field_e      field,
	input  cart_hdr_pkg::rom_word_t       field_data,
	output cart_quirk_pkg::quirk_flags_t  quirks,
	output logic                          gun_type,
	output cart_quirk_pkg::gun_delay_t    gun_delay
);

	import cart_hdr_pkg::*;
	import cart_quirk_pkg::*;

	product_code_t cart_id;
	rom_word_t     swapped;
	quirk_flags_t  quirk_hit;
	logic          check;

	assign swapped = {field_data[7:0], field_data[15:8]};
	assign check   = field_stb && (field == id_check);

	////////////////////////////////////////
	// product code, mid words shift in from the low end
	always_ff @(posedge clk_sys) begin
		if (field_stb) begin
			case (field)
				id_first: cart_id[63:56] <= field_data[15:8];
				id_mid:   cart_id[55:8]  <= {cart_id[39:8], swapped};
				id_last:  cart_id[7:0]   <= field_data[7:0];
				default: ;
			endcase
		end
	end

	// table lookup
	always_comb begin
		quirk_hit = '0;
		for (int i = 0; i < quirk_count; i++) begin
			if (cart_id == quirk_code[i]) quirk_hit = quirk_hit | quirk_mask[i];
		end
	end

	////////////////////////////////////////
	// flags and gun timing, taken at the check word
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			quirks    <= '0;
			gun_type  <= 1'b0;
			gun_delay <= gun_delay_default;
		end else begin
			if (dl_start) quirks <= '0;
			else if (check) quirks <= quirks | quirk_hit;

			if (check) begin
				if (cart_id == code_gun_lethal) begin
					gun_type  <= 1'b1;
					gun_delay <= gun_delay_lethal;
				end else if (cart_id == code_gun_bodycount) begin
					gun_type  <= 1'b0;
					gun_delay <= gun_delay_bodycount;
				end else begin
					gun_type  <= 1'b0;   // no gun entry
					gun_delay <= gun_delay_default;
				end
			end
		end
	end

endmodule

//--- hw/cart_info_result.sv
/*
 * result stage: last word address and rom size, region hold,
 * region_set window and core hold
 */

module cart_info_result (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      host_reset,
	input  logic                      dl_end,
	input  logic                      word_stb,
	input  cart_hdr_pkg::rom_addr_t   stb_addr,
	input  cart_hdr_pkg::region_t     region_in,
	input  logic                      hdr_ready_rise,
	output cart_hdr_pkg::region_t     region,
	output logic                      region_set,
	output cart_hdr_pkg::rom_addr_t   rom_size,
	output logic                      core_hold
);

	import cart_hdr_pkg::*;

	rom_addr_t last_addr;

	// core held in reset while the host asks or the region is being applied
	assign core_hold = host_reset | region_set;

	always_ff @(posedge clk_sys) begin
		if (word_stb) last_addr <= stb_addr;
		if (dl_end) rom_size <= last_addr;   // size = last word address
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			region     <= region_default;
			region_set <= 1'b0;
		end else begin
			if (hdr_ready_rise) begin
				region     <= region_in;
				region_set <= 1'b1;
			end
			if (dl_end) region_set <= 1'b0;   // window closes with the download
		end
	end

endmodule

//--- hw/cart_header_top.sv
/*
 * cartridge header scanner top level
 * word port -> field decode -> region / quirk match -> result
 */

module cart_header_top (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  logic                          host_reset,
	input  logic                          dl_active,
	input  logic                          word_req,
	input  cart_hdr_pkg::rom_addr_t       word_addr,
	input  cart_hdr_pkg::rom_word_t       word_data,
	output logic                          word_ack,
	output cart_hdr_pkg::region_t         region,
	output logic                          region_set,
	output cart_hdr_pkg::rom_addr_t       rom_size,
	output logic                          core_hold,
	output cart_quirk_pkg::quirk_flags_t  quirks,
	output logic                          gun_type,
	output cart_quirk_pkg::gun_delay_t    gun_delay
);

	import cart_hdr_pkg::*;

	logic       word_stb;
	rom_addr_t  stb_addr;
	rom_word_t  stb_data;
	logic       dl_start;
	logic       dl_end;
	logic       field_stb;
	hdr_field_e field;
	rom_word_t  field_data;
	region_t    region_det;
	logic       hdr_ready_rise;

	cart_word_port i_port (
		.clk_sys(clk_sys), .reset(reset), .dl_active(dl_active),
		.word_req(word_req), .word_addr(word_addr), .word_data(word_data),
		.word_ack(word_ack), .word_stb(word_stb), .stb_addr(stb_addr),
		.stb_data(stb_data), .dl_start(dl_start), .dl_end(dl_end)
	);

	hdr_field_decode i_decode (
		.clk_sys(clk_sys), .reset(reset), .word_stb(word_stb),
		.stb_addr(stb_addr), .stb_data(stb_data),
		.field_stb(field_stb), .field(field), .field_data(field_data)
	);

	region_detect i_region (
		.clk_sys(clk_sys), .reset(reset), .dl_start(dl_start), .dl_end(dl_end),
		.field_stb(field_stb), .field(field), .field_data(field_data),
		.region(region_det), .hdr_ready_rise(hdr_ready_rise)
	);

	quirk_match i_quirk (
		.clk_sys(clk_sys), .reset(reset), .dl_start(dl_start),
		.field_stb(field_stb), .field(field), .field_data(field_data),
		.quirks(quirks), .gun_type(gun_type), .gun_delay(gun_delay)
	);

	cart_info_result i_result (
		.clk_sys(clk_sys), .reset(reset), .host_reset(host_reset),
		.dl_end(dl_end), .word_stb(word_stb), .stb_addr(stb_addr),
		.region_in(region_det), .hdr_ready_rise(hdr_ready_rise),
		.region(region), .region_set(region_set), .rom_size(rom_size),
		.core_hold(core_hold)
	);

endmodule

//--- test/tb_cart_header_ref.svh
/*
 * reference model for the header scanner: product code assembly,
 * region pick, quirk flags and light-gun timing per product code
 */

`ifndef TB_CART_HEADER_REF_SVH
`define TB_CART_HEADER_REF_SVH

// product code from the id words as they were sent
function automatic logic [63:0] assemble_code(input logic [15:0] w182, input logic [15:0] w184,
		input logic [15:0] w186, input logic [15:0] w188, input logic [15:0] w18a);
	return {w182[15:8], w184[7:0], w184[15:8], w186[7:0], w186[15:8],
		w188[7:0], w188[15:8], w18a[7:0]};
endfunction

// {e, u, j} for one letter
function automatic logic [2:0] letter_bits(input logic [7:0] ch);
	logic [2:0] bits;
	bits = 3'b000;
	if (ch == "E") bits[2] = 1'b1;
	if (ch == "U") bits[1] = 1'b1;
	if (ch == "J") bits[0] = 1'b1;
	return bits;
endfunction

function automatic logic [1:0] expected_region(input logic [15:0] w1f0, input logic [15:0] w1f2);
	logic [2:0] f;
	logic [7:0] c;
	c = w1f0[7:0];
	f = letter_bits(c);   // E counts as a letter, not as hex
	if (f == 3'b000) begin
		if (c >= "0" && c <= "9") begin
			f = {c[3], c[2], c[0]};
		end else if (c >= "A" && c <= "F") begin
			c = c - 8'd7;
			f = {c[3], c[2], c[0]};
		end
	end
	f = f | letter_bits(w1f0[15:8]) | letter_bits(w1f2[7:0]);
	if (f[1]) return 2'd1;
	else if (f[2]) return 2'd2;
	else if (f[0]) return 2'd0;
	else return 2'd1;   // americas when nothing is marked
endfunction

function automatic logic [7:0] quirks_for_code(input logic [63:0] code);
	logic [7:0] q;
	q = '0;
	case (code)
		"T-081276": q[quirk_sram] = 1'b1;
		" GM 0000": q[quirk_sram00] = 1'b1;
		"MK-1215 ", "G-4060  ": q[quirk_eeprom] = 1'b1;
		"T-113016": q[quirk_noram] = 1'b1;
		"T-89016 ": q[quirk_fifo] = 1'b1;
		"T-574023": q[quirk_pier] = 1'b1;
		"MK-1229 ": q[quirk_svp] = 1'b1;
		"T-35036 ": q[quirk_fmbusy] = 1'b1;
		default: ;
	endcase
	return q;
endfunction

function automatic logic gun_type_for_code(input logic [63:0] code);
	return code == "T-95096-";
endfunction

function automatic logic [7:0] gun_delay_for_code(input logic [63:0] code);
	if (code == "T-95096-") return 8'd52;
	else if (code == "MK-1533 ") return 8'd100;
	else return 8'd44;
endfunction

`endif

//--- test/tb_cart_header.sv
/*
 * testbench for the cartridge header scanner: clock, reset,
 * four-phase word driver, download tests and output checks
 */

module tb_cart_header;

	timeunit 1ns;
	timeprecision 100ps;

	import cart_hdr_pkg::*;
	import cart_quirk_pkg::*;

	`include "tb_cart_header_ref.svh"

	localparam int n_downloads        = 12;
	localparam int words_per_download = 18;   // with 4 trailing words
	localparam int timeout_cycles     = (n_downloads * words_per_download + 2) * 8 + 500;

	localparam logic [63:0] codes [n_downloads] = '{
		"T-081276", " GM 0000", "MK-1215 ", "G-4060  ", "T-113016", "T-89016 ",
		"T-574023", "MK-1229 ", "T-35036 ", "T-95096-", "MK-1533 ", "XX-12345"
	};
	localparam logic [7:0] lo_chars [n_downloads] = '{   // low byte of 0x1f0
		"J", "U", "E", "0", "5", "9", "A", "C", "F", "3", "X", " "
	};
	localparam logic [7:0] side_chars [4] = '{"J", "U", "E", " "};

	logic         clk_sys, reset, host_reset, dl_active, word_req, word_ack;
	rom_addr_t    word_addr;
	rom_word_t    word_data;
	region_t      region;
	logic         region_set;
	rom_addr_t    rom_size;
	logic         core_hold;
	quirk_flags_t quirks;
	logic         gun_type;
	gun_delay_t   gun_delay;

	// expected results of the running download
	region_t      exp_region;
	quirk_flags_t exp_quirks;
	logic         exp_gun_type;
	gun_delay_t   exp_gun_delay;
	rom_addr_t    exp_rom_size;

	int errors = 0;
	int tests_run = 0;
	int tests_bad = 0;
	int compares_done = 0;
	int cycle_count = 0;
	int req_rises = 0;
	int ack_rises = 0;
	int test_no;
	logic req_q = 1'b0;
	logic ack_q = 1'b0;

	cart_header_top i_dut (
		.clk_sys(clk_sys), .reset(reset), .host_reset(host_reset), .dl_active(dl_active),
		.word_req(word_req), .word_addr(word_addr), .word_data(word_data),
		.word_ack(word_ack), .region(region), .region_set(region_set), .rom_size(rom_size),
		.core_hold(core_hold), .quirks(quirks), .gun_type(gun_type), .gun_delay(gun_delay)
	);

	always #10 clk_sys = ~clk_sys;
	always @(posedge clk_sys) cycle_count <= cycle_count + 1;

	////////////////////////////////////////
	// helpers
	task automatic tick();
		@(posedge clk_sys);
		#2;   // inputs change just after the edge
	endtask

	task automatic report_mismatch(input string msg);
		$display("[FAIL] %0t ns: %s", $time, msg);
		errors++;
	endtask

	task automatic protocol_error(input string msg);
		$display("handshake broken at %0t ns: %s", $time, msg);
		errors++;
	endtask

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = $urandom();
		return r[7:0];
	endfunction

	task automatic finish_test(input string name, input int err_before);
		tests_run++;
		if (errors != err_before) tests_bad++;
		$display("test %0d %s: %s", tests_run, name, (errors == err_before) ? "ok" : "mismatch");
	endtask

	// one full four-phase transfer
	task automatic send_word(input rom_addr_t addr, input rom_word_t data);
		int unsigned gap;
		gap = $urandom_range(3, 0);
		repeat (gap) tick();
		word_addr = addr;
		word_data = data;
		word_req  = 1'b1;
		do tick(); while (!word_ack);
		word_req = 1'b0;
		do tick(); while (word_ack);
	endtask

	////////////////////////////////////////
	// tests
	task automatic check_idle_state();
		int err_before;
		err_before = errors;
		if (word_ack !== 1'b0) report_mismatch("word_ack high after reset");
		if (region_set !== 1'b0) report_mismatch("region_set high after reset");
		if (core_hold !== 1'b0) report_mismatch("core_hold high after reset");
		if (quirks !== '0) report_mismatch($sformatf("quirks %0h after reset", quirks));
		if (gun_type !== 1'b0) report_mismatch("gun_type high after reset");
		if (gun_delay !== 8'd44)
			report_mismatch($sformatf("gun_delay %0d after reset, expected 44", gun_delay));
		host_reset = 1'b1;
		tick();
		if (core_hold !== 1'b1) report_mismatch("core_hold low while host_reset high");
		host_reset = 1'b0;
		tick();
		if (core_hold !== 1'b0) report_mismatch("core_hold stuck after host_reset");
		send_word(25'h1F0, {"U", "U"});   // outside a download, ack only
		send_word(25'h200, 16'h0000);
		repeat (3) tick();
		if (region_set !== 1'b0) report_mismatch("region_set from a word outside a download");
		finish_test("idle and reset", err_before);
	endtask

	task automatic run_download(input int n);
		logic [63:0] code;
		logic [63:0] sent_code;
		rom_word_t   id_w [5];
		rom_word_t   w1f0;
		rom_word_t   w1f2;
		rom_addr_t   addr;
		logic [31:0] r;
		int          n_trail;
		int          err_before;
		int          i;

		code    = codes[n];
		id_w[0] = {code[63:56], rand_byte()};
		id_w[1] = {code[47:40], code[55:48]};   // mid words go byte-swapped
		id_w[2] = {code[31:24], code[39:32]};
		id_w[3] = {code[15:8], code[23:16]};
		id_w[4] = {rand_byte(), code[7:0]};
		r       = $urandom();
		w1f0    = {side_chars[r[1:0]], lo_chars[n]};
		w1f2    = {rand_byte(), side_chars[r[3:2]]};
		n_trail = int'(r[5:4]) + 1;

		sent_code     = assemble_code(id_w[0], id_w[1], id_w[2], id_w[3], id_w[4]);
		exp_region    = expected_region(w1f0, w1f2);
		exp_quirks    = quirks_for_code(sent_code);
		exp_gun_type  = gun_type_for_code(sent_code);
		exp_gun_delay = gun_delay_for_code(sent_code);
		err_before    = errors;

		dl_active = 1'b1;
		addr = 25'h100;
		repeat (4) begin
			send_word(addr, {rand_byte(), rand_byte()});
			addr = addr + 25'd2;
		end
		if (quirks !== '0) report_mismatch($sformatf("quirks %0h not cleared at start", quirks));
		if (region_set !== 1'b0) report_mismatch("region_set high before header end");
		send_word(25'h180, {rand_byte(), rand_byte()});
		addr = 25'h182;
		for (i = 0; i < 5; i++) begin
			send_word(addr, id_w[i]);
			addr = addr + 25'd2;
		end
		send_word(25'h18C, {rand_byte(), rand_byte()});   // check word
		send_word(25'h1F0, w1f0);
		send_word(25'h1F2, w1f2);
		send_word(25'h200, {rand_byte(), rand_byte()});
		addr = 25'h200;
		repeat (n_trail) begin
			addr = addr + 25'd2;
			send_word(addr, {rand_byte(), rand_byte()});
		end
		exp_rom_size = addr;
		repeat (3) tick();
		if (region_set !== 1'b1) report_mismatch("region_set low after header end");
		if (core_hold !== 1'b1) report_mismatch("core_hold low while region_set high");
		if (region !== exp_region)
			report_mismatch($sformatf("region %0d, expected %0d", region, exp_region));

		dl_active = 1'b0;
		wait (compares_done == n + 1);
		tick();
		finish_test($sformatf("download \"%s\"", code), err_before);
	endtask

	////////////////////////////////////////
	// checks
	always @(negedge clk_sys) begin
		if (!reset) begin
			if (word_ack && !ack_q && !req_q) protocol_error("ack rose while req low");
			if (!word_ack && ack_q && req_q) protocol_error("ack fell while req high");
			if (word_req && !req_q) begin
				if (req_rises != ack_rises) protocol_error("new req before the last one was acked");
				req_rises++;
			end
			if (word_ack && !ack_q) ack_rises++;
			req_q <= word_req;
			ack_q <= word_ack;
		end
	end

	// results once the download has ended
	initial begin
		@(negedge reset);
		forever begin
			@(negedge dl_active);
			repeat (3) @(negedge clk_sys);   // rom_size lands 2 cycles after the fall
			if (rom_size !== exp_rom_size)
				report_mismatch($sformatf("rom_size %0h, expected %0h", rom_size, exp_rom_size));
			if (region !== exp_region)
				report_mismatch($sformatf("region %0d, expected %0d", region, exp_region));
			if (quirks !== exp_quirks)
				report_mismatch($sformatf("quirks %0h, expected %0h", quirks, exp_quirks));
			if (gun_type !== exp_gun_type)
				report_mismatch($sformatf("gun_type %0b, expected %0b", gun_type, exp_gun_type));
			if (gun_delay !== exp_gun_delay)
				report_mismatch($sformatf("gun_delay %0d, expected %0d", gun_delay, exp_gun_delay));
			if (region_set !== 1'b0) report_mismatch("region_set still high after download");
			if (core_hold !== host_reset) report_mismatch("core_hold differs from host_reset");
			compares_done++;
		end
	end

	initial begin
		wait (cycle_count >= timeout_cycles);
		$display("timeout: run still busy after %0d clock cycles", timeout_cycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'h69770961));
		clk_sys    = 1'b0;
		reset      = 1'b1;
		host_reset = 1'b0;
		dl_active  = 1'b0;
		word_req   = 1'b0;
		word_addr  = '0;
		word_data  = '0;
		repeat (8) @(posedge clk_sys);
		#2;
		reset = 1'b0;
		check_idle_state();
		for (test_no = 0; test_no < n_downloads; test_no++) run_download(test_no);
		if (req_rises != ack_rises)
			protocol_error($sformatf("%0d reqs but %0d acks", req_rises, ack_rises));
		$display("tests run %0d, tests with errors %0d, failed checks %0d",
			tests_run, tests_bad, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- flist.f
+incdir+test
hw/cart_hdr_pkg.sv
hw/cart_quirk_pkg.sv
hw/cart_word_port.sv
hw/hdr_field_decode.sv
hw/region_detect.sv
hw/quirk_match.sv
hw/cart_info_result.sv
hw/cart_header_top.sv
test/tb_cart_header.sv

//--- Makefile
# verilator build and run for the cartridge header scanner testbench

VERILATOR ?= verilator
TOP       ?= tb_cart_header
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j $(JOBS)

SOURCES := $(shell grep -v '^+' $(FLIST)) test/tb_cart_header_ref.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TESTBENCH PASSED'

clean:
	rm -rf $(OBJ_DIR)
